// File: include/rvExec_settings.svh
`ifndef RVEXEC_SETTINGS_SVH
`define RVEXEC_SETTINGS_SVH

`define RVX_XLEN        64
`define RVX_APB_AW      8

`define RVX_REG_INST    8'h00
`define RVX_REG_PC_LO   8'h04
`define RVX_REG_PC_HI   8'h08
`define RVX_REG_RS1_LO  8'h0C
`define RVX_REG_RS1_HI  8'h10
`define RVX_REG_RS2_LO  8'h14
`define RVX_REG_RS2_HI  8'h18
`define RVX_REG_CTRL    8'h1C // bit 0 starts execution
`define RVX_REG_RES_LO  8'h20
`define RVX_REG_RES_HI  8'h24
`define RVX_REG_NPC_LO  8'h28
`define RVX_REG_NPC_HI  8'h2C
`define RVX_REG_STATUS  8'h30

`endif

// File: rtl/aluBranchUnit.sv
`include "rvExec_settings.svh"

module aluBranchUnit import rvExecPkg::*; (
    input  ctrlBundle_t          ctrl,
    input  logic [`RVX_XLEN-1:0] imm,
    input  execIn_t              execIn,
    output execOut_t             execOut
);

    logic [`RVX_XLEN-1:0] opA;
    logic [`RVX_XLEN-1:0] opB;
    logic [`RVX_XLEN-1:0] srcA;
    logic [`RVX_XLEN-1:0] aluRes;
    logic [`RVX_XLEN-1:0] pcPlus4;
    logic [`RVX_XLEN-1:0] jumpTarget;
    logic [5:0]           shamt;
    logic                 isWord;
    logic                 brCond;
    logic                 taken;

    assign opA     = (ctrl.selA == SEL_A_PC) ? execIn.pc : execIn.rs1;
    assign opB     = (ctrl.selB == SEL_B_IMM) ? imm : execIn.rs2;
    assign isWord  = (ctrl.wbSel == WB_ALU_W);
    assign pcPlus4 = execIn.pc + 64'd4;

    // W forms see a 32-bit rs1 and a 5-bit shift amount
    always_comb begin
        if (ctrl.wordShift) begin
            srcA = {32'h0, opA[31:0]};
        end else if (isWord) begin
            srcA = {{32{opA[31]}}, opA[31:0]};
        end else begin
            srcA = opA;
        end
    end
    assign shamt = isWord ? {1'b0, opB[4:0]} : opB[5:0];

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD:    aluRes = srcA + opB;
            ALU_SUB:    aluRes = srcA - opB;
            ALU_SLL:    aluRes = srcA << shamt;
            ALU_SLT:    aluRes = {63'h0, $signed(srcA) < $signed(opB)};
            ALU_SLTU:   aluRes = {63'h0, srcA < opB};
            ALU_XOR:    aluRes = srcA ^ opB;
            ALU_SRL:    aluRes = srcA >> shamt;
            ALU_SRA:    aluRes = $signed(srcA) >>> shamt;
            ALU_OR:     aluRes = srcA | opB;
            ALU_AND:    aluRes = srcA & opB;
            ALU_MUL:    aluRes = srcA * opB; // low 64 bits
            ALU_PASS_A: aluRes = srcA;
            ALU_PASS_B: aluRes = opB;
            default:    aluRes = '0;
        endcase
    end

    always_comb begin
        case (ctrl.brFunct3)
            3'h0:    brCond = (execIn.rs1 == execIn.rs2);
            3'h1:    brCond = (execIn.rs1 != execIn.rs2);
            3'h4:    brCond = ($signed(execIn.rs1) < $signed(execIn.rs2));
            3'h5:    brCond = ($signed(execIn.rs1) >= $signed(execIn.rs2));
            3'h6:    brCond = (execIn.rs1 < execIn.rs2);
            default: brCond = (execIn.rs1 >= execIn.rs2); // bgeu
        endcase
    end

    assign jumpTarget = (ctrl.nextPc == NPC_JALR) ?
                        ((execIn.rs1 + imm) & ~64'h1) : (execIn.pc + imm);
    assign taken      = (ctrl.nextPc == NPC_JAL) || (ctrl.nextPc == NPC_JALR) ||
                        ((ctrl.nextPc == NPC_BRANCH) && brCond);

    always_comb begin
        case (ctrl.wbSel)
            WB_ALU_W: execOut.result = {{32{aluRes[31]}}, aluRes[31:0]};
            WB_PC4:   execOut.result = pcPlus4;
            default:  execOut.result = aluRes;
        endcase
    end

    assign execOut.nextPc            = taken ? jumpTarget : pcPlus4;
    assign execOut.status.illegal    = ctrl.illegal;
    assign execOut.status.trap       = ctrl.trap;
    assign execOut.status.storeMask  = ctrl.storeMask;
    assign execOut.status.loadBytes  = ctrl.loadBytes;
    assign execOut.status.loadSigned = ctrl.loadSigned;
    assign execOut.status.loadEn     = ctrl.loadEn;
    assign execOut.status.taken      = taken;
    assign execOut.status.rdWrite    = ctrl.rdWrite;

endmodule

// File: rtl/apbExecRegs.sv
`include "rvExec_settings.svh"

module apbExecRegs import rvExecPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  apbReq_t  apbReq,
    output apbRsp_t  apbRsp,
    output execIn_t  execIn,
    input  execOut_t execOut
);

    execIn_t     opRegs;
    logic [63:0] resReg;
    logic [63:0] npcReg;
    execStatus_t statusReg;
    logic        valid;
    logic        startPulse;
    logic        access;
    logic        wrEn;
    logic        mapped;
    logic        writable;
    logic [31:0] rdMux;

    assign access = apbReq.psel & apbReq.penable;
    assign wrEn   = access & apbReq.pwrite & writable;

    always_comb begin
        mapped   = 1'b1;
        writable = 1'b0;
        rdMux    = '0;
        case (apbReq.paddr)
            `RVX_REG_INST: begin
                writable = 1'b1;
                rdMux    = opRegs.inst;
            end
            `RVX_REG_PC_LO:  begin writable = 1'b1; rdMux = opRegs.pc[31:0];   end
            `RVX_REG_PC_HI:  begin writable = 1'b1; rdMux = opRegs.pc[63:32];  end
            `RVX_REG_RS1_LO: begin writable = 1'b1; rdMux = opRegs.rs1[31:0];  end
            `RVX_REG_RS1_HI: begin writable = 1'b1; rdMux = opRegs.rs1[63:32]; end
            `RVX_REG_RS2_LO: begin writable = 1'b1; rdMux = opRegs.rs2[31:0];  end
            `RVX_REG_RS2_HI: begin writable = 1'b1; rdMux = opRegs.rs2[63:32]; end
            `RVX_REG_CTRL:   writable = 1'b1; // reads as zero
            `RVX_REG_RES_LO: rdMux = resReg[31:0];
            `RVX_REG_RES_HI: rdMux = resReg[63:32];
            `RVX_REG_NPC_LO: rdMux = npcReg[31:0];
            `RVX_REG_NPC_HI: rdMux = npcReg[63:32];
            `RVX_REG_STATUS: rdMux = {12'h000, statusReg, valid};
            default:         mapped = 1'b0;
        endcase
    end

    assign apbRsp.pready  = 1'b1;
    assign apbRsp.pslverr = access & (~mapped | (apbReq.pwrite & ~writable));
    assign apbRsp.prdata  = (access & ~apbReq.pwrite) ? rdMux : 32'h0;
    assign execIn         = opRegs;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            opRegs     <= '0;
            resReg     <= '0;
            npcReg     <= '0;
            statusReg  <= '0;
            valid      <= 1'b0;
            startPulse <= 1'b0;
        end else begin
            startPulse <= wrEn & (apbReq.paddr == `RVX_REG_CTRL) & apbReq.pwdata[0];
            if (startPulse) begin // capture one edge after start
                resReg    <= execOut.result;
                npcReg    <= execOut.nextPc;
                statusReg <= execOut.status;
                valid     <= 1'b1;
            end
            if (wrEn) begin
                case (apbReq.paddr)
                    `RVX_REG_INST:   opRegs.inst       <= apbReq.pwdata;
                    `RVX_REG_PC_LO:  opRegs.pc[31:0]   <= apbReq.pwdata;
                    `RVX_REG_PC_HI:  opRegs.pc[63:32]  <= apbReq.pwdata;
                    `RVX_REG_RS1_LO: opRegs.rs1[31:0]  <= apbReq.pwdata;
                    `RVX_REG_RS1_HI: opRegs.rs1[63:32] <= apbReq.pwdata;
                    `RVX_REG_RS2_LO: opRegs.rs2[31:0]  <= apbReq.pwdata;
                    `RVX_REG_RS2_HI: opRegs.rs2[63:32] <= apbReq.pwdata;
                    default: ;
                endcase
                if (apbReq.paddr != `RVX_REG_CTRL) begin
                    valid <= 1'b0; // operands changed
                end
            end
        end
    end

endmodule

// File: rtl/immGen.sv
`include "rvExec_settings.svh"

module immGen import rvExecPkg::*; (
    input  logic [31:0]          inst,
    output logic [`RVX_XLEN-1:0] imm
);

    immKind_e          kind;
    logic [`RVX_XLEN-1:0] signFill;

    assign signFill = {`RVX_XLEN{inst[31]}};

    always_comb begin
        case (inst[6:0])
            7'b0000011, 7'b0010011, 7'b0011011, 7'b1100111: kind = IMM_I;
            7'b0100011:             kind = IMM_S;
            7'b1100011:             kind = IMM_B;
            7'b0110111, 7'b0010111: kind = IMM_U;
            7'b1101111:             kind = IMM_J;
            default:                kind = IMM_NONE;
        endcase
    end

    always_comb begin
        imm = '0;
        case (kind)
            IMM_I: imm = {signFill[63:12], inst[31:20]};
            IMM_S: imm = {signFill[63:12], inst[31:25], inst[11:7]};
            IMM_B: imm = {signFill[63:13], inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U: imm = {signFill[63:32], inst[31:12], 12'h000};
            IMM_J: imm = {signFill[63:21], inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0; // no immediate
        endcase
    end

endmodule

// File: rtl/instDecoder.sv
module instDecoder import rvExecPkg::*; (
    input  logic [31:0] inst,
    output ctrlBundle_t ctrl
);

    logic [6:0] opCode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       bad;

    assign opCode = inst[6:0];
    assign funct7 = inst[31:25];
    assign funct3 = inst[14:12];

    always_comb begin
        ctrl            = '0;
        ctrl.aluOp      = ALU_NONE;
        ctrl.selA       = SEL_A_RS1;
        ctrl.selB       = SEL_B_RS2;
        ctrl.wbSel      = WB_ALU;
        ctrl.nextPc     = NPC_SEQ;
        ctrl.brFunct3   = funct3;
        ctrl.trap       = TRAP_NONE;
        bad             = 1'b0;
        case (opCode)
            7'b0110011: begin // R type
                ctrl.rdWrite = 1'b1;
                case ({funct7, funct3})
                    10'h000: ctrl.aluOp = ALU_ADD;
                    10'h001: ctrl.aluOp = ALU_SLL;
                    10'h002: ctrl.aluOp = ALU_SLT;
                    10'h003: ctrl.aluOp = ALU_SLTU;
                    10'h004: ctrl.aluOp = ALU_XOR;
                    10'h005: ctrl.aluOp = ALU_SRL;
                    10'h006: ctrl.aluOp = ALU_OR;
                    10'h007: ctrl.aluOp = ALU_AND;
                    10'h100: ctrl.aluOp = ALU_SUB;
                    10'h105: ctrl.aluOp = ALU_SRA;
                    10'h008: ctrl.aluOp = ALU_MUL;
                    default: bad = 1'b1; // mulh and div family
                endcase
            end
            7'b0010011: begin // I type arithmetic
                ctrl.selB    = SEL_B_IMM;
                ctrl.rdWrite = 1'b1;
                case (funct3)
                    3'h0: ctrl.aluOp = ALU_ADD;
                    3'h2: ctrl.aluOp = ALU_SLT;
                    3'h3: ctrl.aluOp = ALU_SLTU;
                    3'h4: ctrl.aluOp = ALU_XOR;
                    3'h6: ctrl.aluOp = ALU_OR;
                    3'h7: ctrl.aluOp = ALU_AND;
                    3'h1: begin
                        ctrl.aluOp = ALU_SLL;
                        bad        = (funct7[6:1] != 6'h00);
                    end
                    default: begin // srli / srai
                        ctrl.aluOp = funct7[5] ? ALU_SRA : ALU_SRL;
                        bad        = (funct7[6:1] != 6'h00) && (funct7[6:1] != 6'h10);
                    end
                endcase
            end
            7'b0111011: begin // R type W
                ctrl.rdWrite = 1'b1;
                ctrl.wbSel   = WB_ALU_W;
                case ({funct7, funct3})
                    10'h000: ctrl.aluOp = ALU_ADD;
                    10'h001: ctrl.aluOp = ALU_SLL;
                    10'h100: ctrl.aluOp = ALU_SUB;
                    10'h105: ctrl.aluOp = ALU_SRA;
                    10'h008: ctrl.aluOp = ALU_MUL;
                    10'h005: begin
                        ctrl.aluOp     = ALU_SRL;
                        ctrl.wordShift = 1'b1;
                    end
                    default: bad = 1'b1;
                endcase
            end
            7'b0011011: begin // I type W
                ctrl.selB    = SEL_B_IMM;
                ctrl.rdWrite = 1'b1;
                ctrl.wbSel   = WB_ALU_W;
                case ({funct7, funct3})
                    10'h001: ctrl.aluOp = ALU_SLL;
                    10'h105: ctrl.aluOp = ALU_SRA;
                    10'h005: begin
                        ctrl.aluOp     = ALU_SRL;
                        ctrl.wordShift = 1'b1;
                    end
                    default: begin
                        ctrl.aluOp = ALU_ADD; // addiw takes any funct7
                        bad        = (funct3 != 3'h0);
                    end
                endcase
            end
            7'b0110111: begin // lui
                ctrl.selB    = SEL_B_IMM;
                ctrl.aluOp   = ALU_PASS_B;
                ctrl.rdWrite = 1'b1;
            end
            7'b0010111: begin // auipc
                ctrl.selA    = SEL_A_PC;
                ctrl.selB    = SEL_B_IMM;
                ctrl.aluOp   = ALU_ADD;
                ctrl.rdWrite = 1'b1;
            end
            7'b1101111: begin // jal
                ctrl.nextPc  = NPC_JAL;
                ctrl.wbSel   = WB_PC4;
                ctrl.rdWrite = 1'b1;
            end
            7'b1100111: begin // jalr
                ctrl.nextPc  = NPC_JALR;
                ctrl.wbSel   = WB_PC4;
                ctrl.rdWrite = 1'b1;
                bad          = (funct3 != 3'h0);
            end
            7'b1100011: begin // branches
                ctrl.nextPc = NPC_BRANCH;
                bad         = (funct3 == 3'h2) || (funct3 == 3'h3);
            end
            7'b0000011: begin // loads return the address
                ctrl.selB       = SEL_B_IMM;
                ctrl.aluOp      = ALU_ADD;
                ctrl.rdWrite    = 1'b1;
                ctrl.loadEn     = 1'b1;
                ctrl.loadSigned = ~funct3[2];
                ctrl.loadBytes  = 4'h1 << funct3[1:0];
                bad             = (funct3 == 3'h7);
            end
            7'b0100011: begin // stores
                ctrl.selB      = SEL_B_IMM;
                ctrl.aluOp     = ALU_ADD;
                ctrl.storeMask = 8'hFF >> (4'd8 - (4'd1 << funct3[1:0]));
                bad            = funct3[2];
            end
            7'b1110011: begin
                case (inst)
                    32'h0000_0073: ctrl.trap = TRAP_ECALL;
                    32'h0010_0073: ctrl.trap = TRAP_EBREAK;
                    32'h3020_0073: ctrl.trap = TRAP_MRET;
                    default:       bad = 1'b1; // csr access
                endcase
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            ctrl            = '0;
            ctrl.aluOp      = ALU_NONE;
            ctrl.nextPc     = NPC_SEQ;
            ctrl.brFunct3   = funct3;
            ctrl.trap       = TRAP_NONE;
            ctrl.illegal    = 1'b1;
        end
    end

endmodule

// File: rtl/rvExecPkg.sv
`include "rvExec_settings.svh"

package rvExecPkg;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
        ALU_SRA, ALU_OR, ALU_AND, ALU_MUL, ALU_PASS_A, ALU_PASS_B, ALU_NONE
    } aluOp_e;

    typedef enum logic {SEL_A_PC, SEL_A_RS1} opSelA_e;
    typedef enum logic {SEL_B_IMM, SEL_B_RS2} opSelB_e;

    typedef enum logic [1:0] {WB_ALU, WB_ALU_W, WB_PC4} wbSel_e; // WB_ALU_W sign-extends bit 31
    typedef enum logic [1:0] {NPC_SEQ, NPC_JAL, NPC_JALR, NPC_BRANCH} nextPc_e;
    typedef enum logic [1:0] {TRAP_NONE, TRAP_ECALL, TRAP_EBREAK, TRAP_MRET} trapKind_e;
    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_NONE} immKind_e;

    typedef struct packed {
        aluOp_e     aluOp;
        opSelA_e    selA;
        opSelB_e    selB;
        wbSel_e     wbSel;
        nextPc_e    nextPc;
        logic [2:0] brFunct3;
        logic       rdWrite;
        logic       loadEn;
        logic [3:0] loadBytes;
        logic       loadSigned;
        logic [7:0] storeMask;
        logic       wordShift; // srlw/srliw see rs1 zero-extended
        trapKind_e  trap;
        logic       illegal;
    } ctrlBundle_t;

    typedef struct packed {
        logic [31:0]          inst;
        logic [`RVX_XLEN-1:0] pc;
        logic [`RVX_XLEN-1:0] rs1;
        logic [`RVX_XLEN-1:0] rs2;
    } execIn_t;

    // STATUS register bits [19:1], bit 0 is valid
    typedef struct packed {
        logic       illegal;    // bit 19
        trapKind_e  trap;       // bits 18:17
        logic [7:0] storeMask;  // bits 16:9
        logic [3:0] loadBytes;  // bits 8:5
        logic       loadSigned; // bit 4
        logic       loadEn;     // bit 3
        logic       taken;      // bit 2
        logic       rdWrite;    // bit 1
    } execStatus_t;

    typedef struct packed {
        logic [`RVX_XLEN-1:0] result;
        logic [`RVX_XLEN-1:0] nextPc;
        execStatus_t          status;
    } execOut_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`RVX_APB_AW-1:0] paddr;
        logic [31:0]            pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp_t;

endpackage

// File: rtl/rvExecTop.sv
`include "rvExec_settings.svh"

module rvExecTop import rvExecPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  apbReq_t apbReq,
    output apbRsp_t apbRsp
);

    execIn_t              execIn;
    execOut_t             execOut;
    ctrlBundle_t          ctrl;
    logic [`RVX_XLEN-1:0] imm;

    apbExecRegs u_apbExecRegs (
        .clk     (clk),
        .arstN   (arstN),
        .apbReq  (apbReq),
        .apbRsp  (apbRsp),
        .execIn  (execIn),
        .execOut (execOut)
    );

    instDecoder u_instDecoder (
        .inst (execIn.inst),
        .ctrl (ctrl)
    );

    immGen u_immGen (
        .inst (execIn.inst),
        .imm  (imm)
    );

    aluBranchUnit u_aluBranchUnit (
        .ctrl    (ctrl),
        .imm     (imm),
        .execIn  (execIn),
        .execOut (execOut)
    );

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbRvExec -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/VtbRvExec)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "Verification passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sim/tbRvExec.sv
`include "rvExec_settings.svh"

module tbRvExec import rvExecPkg::*; ();

    localparam int NUM_OPS  = 460; // issued instructions rounded up
    localparam int CLK_HALF = 10;

    logic    clk = 1'b0;
    logic    arstN;
    apbReq_t apbReq;
    apbRsp_t apbRsp;

    rvExecTop u_rvExecTop (
        .clk    (clk),
        .arstN  (arstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp)
    );

    always #CLK_HALF clk = ~clk;

    initial begin
        #(NUM_OPS * 400 * 20);
        $display("Timeout: the directed tests did not finish before the watchdog expired");
        $display("Verification failed");
        $fatal(1);
    end

    task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic logic [63:0] sx32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // rd = x1, rs1 = x2, rs2 = x3 throughout
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [6:0] op);
        return {f7, 5'd3, 5'd2, f3, 5'd1, op};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [6:0] op);
        return {imm, 5'd2, f3, 5'd1, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd3, 5'd2, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd3, 5'd2, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [6:0] op);
        return {imm, 5'd1, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'h6f};
    endfunction

    // STATUS layout with valid in bit 0
    function automatic logic [31:0] statusWord(input bit ill, input logic [1:0] trap,
            input logic [7:0] mask, input logic [3:0] bytes, input bit lSigned,
            input bit lEn, input bit taken, input bit rdw);
        return {12'h000, ill, trap, mask, bytes, lSigned, lEn, taken, rdw, 1'b1};
    endfunction

    function automatic bit branchTaken(input logic [2:0] f3, input logic [63:0] a,
                                       input logic [63:0] b);
        case (f3)
            3'h0:    return a == b;
            3'h1:    return a != b;
            3'h4:    return $signed(a) < $signed(b);
            3'h5:    return $signed(a) >= $signed(b);
            3'h6:    return a < b;
            3'h7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic apbXfer(input bit isWrite, input logic [7:0] addr, input logic [31:0] wdata,
                           input bit expErr, output logic [31:0] rdata);
        logic err;
        logic rdy;
        @(posedge clk);
        #2;
        apbReq.psel    = 1'b1; // setup
        apbReq.penable = 1'b0;
        apbReq.pwrite  = isWrite;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(posedge clk);
        #2;
        apbReq.penable = 1'b1; // access
        #8;
        err   = apbRsp.pslverr;
        rdy   = apbRsp.pready;
        rdata = apbRsp.prdata;
        @(posedge clk);
        #2;
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
        checkEq("pready", {63'h0, rdy}, 64'h1);
        checkEq($sformatf("pslverr at 0x%h", addr), {63'h0, err}, {63'h0, expErr});
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, input bit expErr);
        logic [31:0] rdIgnored;
        apbXfer(1'b1, addr, data, expErr, rdIgnored);
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, input bit expErr);
        apbXfer(1'b0, addr, 32'h0, expErr, data);
    endtask

    task automatic runInst(input logic [31:0] inst, input logic [63:0] pc,
                           input logic [63:0] rs1, input logic [63:0] rs2, input bit checkRes,
                           input logic [63:0] expRes, input logic [63:0] expNpc,
                           input logic [31:0] expStatus);
        logic [31:0] lo;
        logic [31:0] hi;
        apbWrite(`RVX_REG_INST, inst, 1'b0);
        apbWrite(`RVX_REG_PC_LO, pc[31:0], 1'b0);
        apbWrite(`RVX_REG_PC_HI, pc[63:32], 1'b0);
        apbWrite(`RVX_REG_RS1_LO, rs1[31:0], 1'b0);
        apbWrite(`RVX_REG_RS1_HI, rs1[63:32], 1'b0);
        apbWrite(`RVX_REG_RS2_LO, rs2[31:0], 1'b0);
        apbWrite(`RVX_REG_RS2_HI, rs2[63:32], 1'b0);
        apbWrite(`RVX_REG_CTRL, 32'h1, 1'b0);
        if (checkRes) begin
            apbRead(`RVX_REG_RES_LO, lo, 1'b0);
            apbRead(`RVX_REG_RES_HI, hi, 1'b0);
            checkEq($sformatf("result of inst 0x%h", inst), {hi, lo}, expRes);
        end
        apbRead(`RVX_REG_NPC_LO, lo, 1'b0);
        apbRead(`RVX_REG_NPC_HI, hi, 1'b0);
        checkEq($sformatf("nextPc of inst 0x%h", inst), {hi, lo}, expNpc);
        apbRead(`RVX_REG_STATUS, lo, 1'b0);
        checkEq($sformatf("status of inst 0x%h", inst), {32'h0, lo}, {32'h0, expStatus});
    endtask

    task automatic arith(input logic [31:0] inst, input logic [63:0] pc, input logic [63:0] a,
                         input logic [63:0] b, input logic [63:0] exp);
        runInst(inst, pc, a, b, 1'b1, exp, pc + 64'd4,
                statusWord(1'b0, 2'd0, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0, 1'b1));
    endtask

    task automatic testApb();
        logic [31:0] d;
        logic [31:0] v;
        logic [7:0]  addr;
        for (int i = 0; i <= 12; i++) begin // every mapped register
            addr = 8'(i * 4);
            apbRead(addr, d, 1'b0);
            checkEq($sformatf("reset value at 0x%h", addr), {32'h0, d}, 64'h0);
        end
        apbRead(8'h34, d, 1'b1);
        apbRead(8'hFC, d, 1'b1);
        apbWrite(`RVX_REG_RES_LO, 32'h1234_5678, 1'b1);
        apbWrite(`RVX_REG_STATUS, 32'h1, 1'b1);
        for (int i = 0; i <= 6; i++) begin // INST through RS2_HI
            addr = 8'(i * 4);
            v    = $urandom;
            apbWrite(addr, v, 1'b0);
            apbRead(addr, d, 1'b0);
            checkEq($sformatf("readback at 0x%h", addr), {32'h0, d}, {32'h0, v});
        end
        arith(encI(12'h005, 3'h0, 7'h13), 64'h100, 64'h7, 64'h0, 64'hC);
        apbWrite(`RVX_REG_RS2_LO, 32'hCAFE, 1'b0);
        apbRead(`RVX_REG_STATUS, d, 1'b0);
        checkEq("valid after operand write", {63'h0, d[0]}, 64'h0);
        apbWrite(`RVX_REG_CTRL, 32'h1, 1'b0);
        apbRead(`RVX_REG_STATUS, d, 1'b0);
        checkEq("valid after start", {63'h0, d[0]}, 64'h1);
    endtask

    task automatic testArith();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] pc;
        logic [63:0] immI;
        logic [11:0] imm;
        logic [5:0]  sh;
        for (int n = 0; n < 20; n++) begin
            a    = rand64();
            b    = rand64();
            pc   = rand64() & ~64'h3;
            imm  = 12'($urandom);
            sh   = 6'($urandom);
            immI = sext12(imm);
            arith(encR(7'h00, 3'h0, 7'h33), pc, a, b, a + b);
            arith(encR(7'h20, 3'h0, 7'h33), pc, a, b, a - b);
            arith(encR(7'h00, 3'h1, 7'h33), pc, a, b, a << b[5:0]);
            arith(encR(7'h00, 3'h2, 7'h33), pc, a, b, {63'h0, $signed(a) < $signed(b)});
            arith(encR(7'h00, 3'h3, 7'h33), pc, a, b, {63'h0, a < b});
            arith(encR(7'h00, 3'h4, 7'h33), pc, a, b, a ^ b);
            arith(encR(7'h00, 3'h5, 7'h33), pc, a, b, a >> b[5:0]);
            arith(encR(7'h20, 3'h5, 7'h33), pc, a, b, $signed(a) >>> b[5:0]);
            arith(encR(7'h00, 3'h6, 7'h33), pc, a, b, a | b);
            arith(encR(7'h00, 3'h7, 7'h33), pc, a, b, a & b);
            arith(encR(7'h01, 3'h0, 7'h33), pc, a, b, a * b); // mul keeps the low half
            arith(encI(imm, 3'h0, 7'h13), pc, a, b, a + immI);
            arith(encI(imm, 3'h3, 7'h13), pc, a, b, {63'h0, a < immI});
            arith(encI(imm, 3'h4, 7'h13), pc, a, b, a ^ immI);
            arith(encI(imm, 3'h7, 7'h13), pc, a, b, a & immI);
            arith(encI({6'h00, sh}, 3'h1, 7'h13), pc, a, b, a << sh);
            arith(encI({6'h10, sh}, 3'h5, 7'h13), pc, a, b, $signed(a) >>> sh);
        end
    endtask

    task automatic testWord();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] pc;
        logic [11:0] imm;
        logic [4:0]  sh;
        for (int n = 0; n < 6; n++) begin
            a   = rand64();
            b   = rand64();
            pc  = rand64() & ~64'h3;
            imm = 12'($urandom);
            sh  = 5'($urandom);
            arith(encR(7'h00, 3'h0, 7'h3b), pc, a, b, sx32(a[31:0] + b[31:0]));
            arith(encR(7'h20, 3'h0, 7'h3b), pc, a, b, sx32(a[31:0] - b[31:0]));
            arith(encR(7'h00, 3'h1, 7'h3b), pc, a, b, sx32(a[31:0] << b[4:0]));
            arith(encR(7'h00, 3'h5, 7'h3b), pc, a, b, sx32(a[31:0] >> b[4:0]));
            arith(encR(7'h20, 3'h5, 7'h3b), pc, a, b, sx32($signed(a[31:0]) >>> b[4:0]));
            arith(encR(7'h01, 3'h0, 7'h3b), pc, a, b, sx32(a[31:0] * b[31:0]));
            arith(encI(imm, 3'h0, 7'h1b), pc, a, b, sx32(32'(a + sext12(imm))));
            arith(encI({7'h20, sh}, 3'h5, 7'h1b), pc, a, b, sx32($signed(a[31:0]) >>> sh));
        end
    endtask

    task automatic testFlow();
        logic [63:0] pa [3];
        logic [63:0] pb [3];
        logic [63:0] pc;
        logic [63:0] rs1;
        logic [12:0] offB;
        logic [20:0] offJ;
        logic [11:0] offI;
        bit          tk;
        pa = '{64'hFFFF_FFFF_FFFF_FFFF, 64'h3, 64'h1}; // -1 vs 1, equal, 1 vs -1
        pb = '{64'h1, 64'h3, 64'hFFFF_FFFF_FFFF_FFFF};
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) begin
                continue;
            end
            for (int p = 0; p < 3; p++) begin
                pc   = rand64() & ~64'h3;
                offB = (p == 1) ? 13'h1FF0 : 13'h0124;
                tk   = branchTaken(f[2:0], pa[p], pb[p]);
                runInst(encB(offB, f[2:0]), pc, pa[p], pb[p], 1'b0, 64'h0,
                        tk ? pc + {{51{offB[12]}}, offB} : pc + 64'd4,
                        statusWord(1'b0, 2'd0, 8'h00, 4'h0, 1'b0, 1'b0, tk, 1'b0));
            end
        end
        for (int n = 0; n < 2; n++) begin
            pc   = rand64() & ~64'h3;
            rs1  = rand64() & ~64'h1; // even base
            offJ = (n == 0) ? 21'h0_1234 : 21'h1F_F000;
            offI = (n == 0) ? 12'h7FF : 12'h801; // odd sums test bit 0 clearing
            runInst(encJ(offJ), pc, rs1, 64'h0, 1'b1, pc + 64'd4,
                    pc + {{43{offJ[20]}}, offJ},
                    statusWord(1'b0, 2'd0, 8'h00, 4'h0, 1'b0, 1'b0, 1'b1, 1'b1));
            runInst(encI(offI, 3'h0, 7'h67), pc, rs1, 64'h0, 1'b1, pc + 64'd4,
                    (rs1 + sext12(offI)) & ~64'h1,
                    statusWord(1'b0, 2'd0, 8'h00, 4'h0, 1'b0, 1'b0, 1'b1, 1'b1));
        end
    endtask

    task automatic testMemory();
        logic [3:0]  ldSize [6];
        logic [7:0]  stMask [4];
        logic [63:0] pc;
        logic [63:0] rs1;
        logic [11:0] imm;
        logic [19:0] u;
        ldSize = '{4'd1, 4'd2, 4'd4, 4'd8, 4'd1, 4'd2}; // lb lh lw ld lbu lhu
        stMask = '{8'h01, 8'h03, 8'h0F, 8'hFF};
        for (int f = 0; f < 6; f++) begin
            pc  = rand64() & ~64'h3;
            rs1 = rand64();
            imm = 12'($urandom);
            runInst(encI(imm, f[2:0], 7'h03), pc, rs1, 64'h0, 1'b1, rs1 + sext12(imm),
                    pc + 64'd4,
                    statusWord(1'b0, 2'd0, 8'h00, ldSize[f], f < 4, 1'b1, 1'b0, 1'b1));
        end
        for (int f = 0; f < 4; f++) begin
            pc  = rand64() & ~64'h3;
            rs1 = rand64();
            imm = 12'($urandom);
            runInst(encS(imm, f[2:0]), pc, rs1, rand64(), 1'b1, rs1 + sext12(imm),
                    pc + 64'd4,
                    statusWord(1'b0, 2'd0, stMask[f], 4'h0, 1'b0, 1'b0, 1'b0, 1'b0));
        end
        pc = rand64() & ~64'h3;
        u  = 20'($urandom);
        arith(encU(u, 7'h37), pc, rand64(), 64'h0, {{32{u[19]}}, u, 12'h000});
        arith(encU(u, 7'h17), pc, rand64(), 64'h0, pc + {{32{u[19]}}, u, 12'h000});
    endtask

    task automatic testTraps();
        logic [63:0] pc;
        logic [63:0] rs1;
        logic [63:0] rs2;
        logic [31:0] illStat;
        pc      = rand64() & ~64'h3;
        rs1     = rand64();
        rs2     = rand64();
        illStat = statusWord(1'b1, 2'd0, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
        runInst(32'h0000_0073, pc, rs1, rs2, 1'b0, 64'h0, pc + 64'd4,
                statusWord(1'b0, 2'd1, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0));
        runInst(32'h0010_0073, pc, rs1, rs2, 1'b0, 64'h0, pc + 64'd4,
                statusWord(1'b0, 2'd2, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0));
        runInst(32'h3020_0073, pc, rs1, rs2, 1'b0, 64'h0, pc + 64'd4,
                statusWord(1'b0, 2'd3, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0));
        runInst(encI(12'h300, 3'h1, 7'h73), pc, rs1, rs2, 1'b0, 64'h0, pc + 64'd4,
                illStat); // csrrw
        runInst(encR(7'h01, 3'h4, 7'h33), pc, rs1, rs2, 1'b0, 64'h0, pc + 64'd4,
                illStat); // div
    endtask

    initial begin
        arstN  = 1'b0;
        apbReq = '0;
        void'($urandom(32'h23a80025));
        repeat (8) @(posedge clk);
        #2;
        arstN = 1'b1;
        #4;
        checkEq("prdata after reset", {32'h0, apbRsp.prdata}, 64'h0);
        checkEq("pslverr after reset", {63'h0, apbRsp.pslverr}, 64'h0);
        testApb();
        testArith();
        testWord();
        testFlow();
        testMemory();
        testTraps();
        $display("Verification passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
rtl/rvExecPkg.sv
rtl/instDecoder.sv
rtl/immGen.sv
rtl/aluBranchUnit.sv
rtl/apbExecRegs.sv
rtl/rvExecTop.sv
sim/tbRvExec.sv
